// File: aluUnit.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module aluUnit
	import pipePkg::*;
(
	input aluOpE aluOp,
	input wordT a,
	input wordT b,
	output wordT result,
	output logic taken
);

	logic [$clog2(`PIPE_XLEN)-1:0] shamt;
	wordT sum;

	assign shamt = b[$clog2(`PIPE_XLEN)-1:0];
	assign sum = a + b;

	always_comb
	begin
		result = sum;    // Compare codes keep the sum
		taken = 1'b0;
		case (aluOp)
			ALU_ADD:  result = sum;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = wordT'($signed(a) < $signed(b));
			ALU_SLTU: result = wordT'(a < b);
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt;
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			ALU_BEQ:  taken = (a == b);
			ALU_BNE:  taken = (a != b);
			ALU_BLT:  taken = ($signed(a) < $signed(b));
			ALU_BGE:  taken = ($signed(a) >= $signed(b));
			ALU_BLTU: taken = (a < b);
			ALU_BGEU: taken = (a >= b);
			default:
			begin
				result = sum;
				taken = 1'b0;
			end
		endcase
	end

endmodule

// File: files.f
+incdir+.
pipePkg.sv
pipeCtrl.sv
immGen.sv
aluUnit.sv
regFile.sv
hazardUnit.sv
pipeCore.sv
tbModels.sv
pipeCoreTb.sv

// File: hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit
	import pipePkg::*;
(
	input regIdxT idRs1,
	input regIdxT idRs2,
	input regIdxT exRs1,
	input regIdxT exRs2,
	input regIdxT exRd,
	input logic exIsLoad,
	input regIdxT memRd,
	input logic memRegWrite,
	input regIdxT wbRd,
	input logic wbRegWrite,
	input logic branchTaken,
	output logic [1:0] forwardA,    // 10 memory, 01 writeback, 00 register
	output logic [1:0] forwardB,
	output logic stall,
	output logic flush
);

	logic memHit;
	logic wbHit;

	assign memHit = memRegWrite && (memRd != '0);
	assign wbHit = wbRegWrite && (wbRd != '0);

	always_comb
	begin
		forwardA = 2'b00;
		if (memHit && memRd == exRs1)
			forwardA = 2'b10;
		else if (wbHit && wbRd == exRs1)
			forwardA = 2'b01;

		forwardB = 2'b00;
		if (memHit && memRd == exRs2)
			forwardB = 2'b10;
		else if (wbHit && wbRd == exRs2)
			forwardB = 2'b01;
	end

	// Load result not ready until writeback
	assign stall = exIsLoad && (exRd != '0) && (exRd == idRs1 || exRd == idRs2);
	assign flush = branchTaken;

endmodule

// File: immGen.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module immGen
	import pipePkg::*;
(
	input logic [31:0] instr,
	output logic [`PIPE_XLEN-1:0] imm
);

	logic sign;

	assign sign = instr[31];

	always_comb
	begin
		case (instr[6:0])
			OPC_IMM, OPC_LOAD, OPC_JALR:
			begin
				imm = {{(`PIPE_XLEN-12){sign}}, instr[31:20]};
			end
			OPC_STORE:
			begin
				imm = {{(`PIPE_XLEN-12){sign}}, instr[31:25], instr[11:7]};
			end
			OPC_BRANCH:
			begin
				imm = {{(`PIPE_XLEN-13){sign}}, sign, instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			OPC_JAL:
			begin
				imm = {{(`PIPE_XLEN-21){sign}}, sign, instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default:
			begin
				imm = '0;
			end
		endcase
	end

endmodule

// File: pipeCore.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module pipeCore
	import pipePkg::*;
(
	input logic clk,
	input logic reset,
	output wordT imemAddr,
	input wordT imemData,
	output dmemReqT dmemReq,
	input wordT dmemRdata,
	output retireT retire
);

	wordT pc;
	wordT ifIdPc;
	logic [31:0] ifIdInstr;
	logic ifIdValid;

	ctrlT decCtrl;
	ctrlT idCtrl;
	wordT idImm;
	wordT idRs1Data;
	wordT idRs2Data;

	idExT idEx, idExNext;
	exMemT exMem, exMemNext;
	memWbT memWb, memWbNext;

	logic [1:0] forwardA, forwardB;
	logic stall, flush;

	wordT fwdA, fwdB, aluA, aluB, aluResult, exResult;
	wordT branchTarget, redirectPc;
	logic aluTaken, redirect;

	wordT wbData;
	logic wbWrite;

	// Fetch
	assign imemAddr = pc;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= `PIPE_RESET_PC;
		else if (redirect)
			pc <= redirectPc;
		else if (!stall)
			pc <= pc + wordT'(4);
	end

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			ifIdValid <= 1'b0;
		else if (!stall)
			ifIdValid <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			ifIdPc <= pc;
			ifIdInstr <= imemData;
		end
	end

	// Decode
	pipeCtrl ctrlDec (.instr(ifIdInstr), .ctrl(decCtrl));
	immGen immDec (.instr(ifIdInstr), .imm(idImm));

	regFile regs (
		.clk(clk),
		.reset(reset),
		.readAddrA(ifIdInstr[19:15]),
		.readAddrB(ifIdInstr[24:20]),
		.readDataA(idRs1Data),
		.readDataB(idRs2Data),
		.writeEn(wbWrite),
		.writeAddr(memWb.rd),
		.writeData(wbData)
	);

	assign idCtrl = ifIdValid ? decCtrl : '0;

	always_comb
	begin
		idExNext.ctrl = idCtrl;
		idExNext.pc = ifIdPc;
		idExNext.rs1Data = idRs1Data;
		idExNext.rs2Data = idRs2Data;
		idExNext.imm = idImm;
		idExNext.rs1 = ifIdInstr[19:15];
		idExNext.rs2 = ifIdInstr[24:20];
		idExNext.rd = ifIdInstr[11:7];
	end

	always_ff @(posedge clk)
	begin
		idEx <= idExNext;
		if (reset || flush || stall)
			idEx.ctrl <= '0;    // Bubble into execute
	end

	hazardUnit hazards (
		.idRs1(idExNext.rs1),
		.idRs2(idExNext.rs2),
		.exRs1(idEx.rs1),
		.exRs2(idEx.rs2),
		.exRd(idEx.rd),
		.exIsLoad(idEx.ctrl.isLoad),
		.memRd(exMem.rd),
		.memRegWrite(exMem.ctrl.regWrite),
		.wbRd(memWb.rd),
		.wbRegWrite(memWb.ctrl.regWrite),
		.branchTaken(redirect),
		.forwardA(forwardA),
		.forwardB(forwardB),
		.stall(stall),
		.flush(flush)
	);

	// Execute
	always_comb
	begin
		case (forwardA)
			2'b10: fwdA = exMem.result;
			2'b01: fwdA = wbData;
			default: fwdA = idEx.rs1Data;
		endcase
		case (forwardB)
			2'b10: fwdB = exMem.result;
			2'b01: fwdB = wbData;
			default: fwdB = idEx.rs2Data;
		endcase
	end

	assign aluA = idEx.ctrl.aluSrcA ? fwdA : idEx.pc;
	assign aluB = idEx.ctrl.aluSrcB ? idEx.imm : fwdB;

	aluUnit alu (.aluOp(idEx.ctrl.aluOp), .a(aluA), .b(aluB), .result(aluResult),
		.taken(aluTaken));

	assign exResult = (idEx.ctrl.wbSrc == WB_PC4) ? idEx.pc + wordT'(4) : aluResult;
	assign branchTarget = idEx.pc + idEx.imm;

	assign redirect = idEx.ctrl.valid && (idEx.ctrl.pcSrc == PC_TARGET)
		&& (idEx.ctrl.isJump || (idEx.ctrl.isBranch && aluTaken));
	assign redirectPc = idEx.ctrl.isJump ? {aluResult[`PIPE_XLEN-1:1], 1'b0} : branchTarget;

	always_comb
	begin
		exMemNext.ctrl = idEx.ctrl;
		exMemNext.result = exResult;
		exMemNext.storeData = fwdB;
		exMemNext.rd = idEx.rd;
	end

	always_ff @(posedge clk)
	begin
		exMem <= exMemNext;
		if (reset)
			exMem.ctrl <= '0;
	end

	// Memory
	assign dmemReq.addr = exMem.result;
	assign dmemReq.wdata = exMem.storeData;
	assign dmemReq.be = exMem.ctrl.memWrite ? 4'b1111 : 4'b0000;    // Word stores only
	assign dmemReq.write = exMem.ctrl.memWrite;
	assign dmemReq.read = exMem.ctrl.memRead;

	always_comb
	begin
		memWbNext.ctrl = exMem.ctrl;
		memWbNext.result = exMem.result;
		memWbNext.memData = dmemRdata;
		memWbNext.rd = exMem.rd;
	end

	always_ff @(posedge clk)
	begin
		memWb <= memWbNext;
		if (reset)
			memWb.ctrl <= '0;
	end

	// Writeback
	assign wbData = (memWb.ctrl.wbSrc == WB_MEM) ? memWb.memData : memWb.result;
	assign wbWrite = memWb.ctrl.valid && memWb.ctrl.regWrite;

	assign retire.strobe = wbWrite;
	assign retire.rd = memWb.rd;
	assign retire.data = (memWb.rd == '0) ? '0 : wbData;

endmodule

// File: pipeCoreTb.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module pipeCoreTb
	import pipePkg::*;
();

	logic clk;
	logic reset;
	wordT imemAddr;
	wordT imemData;
	wordT dmemRdata;
	dmemReqT dmemReq;
	retireT retire;

	logic [31:0] rng;
	int progLen;
	int cycle = 0;
	int cycleLimit;
	int fetchCycle;
	logic checking;
	logic firstRetireSeen;

	pipeCore uut (.clk(clk), .reset(reset), .imemAddr(imemAddr), .imemData(imemData),
		.dmemReq(dmemReq), .dmemRdata(dmemRdata), .retire(retire));

	tbModels models (.clk(clk), .imemAddr(imemAddr), .imemData(imemData),
		.dmemReq(dmemReq), .dmemRdata(dmemRdata));

	always #10 clk = ~clk;

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input wordT expected, input wordT actual);
		failRun($sformatf("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int randomImm();
		rng = xorshift(rng);
		return int'(rng[11:0]);
	endfunction

	// Instruction encoders
	function automatic wordT regOp(input int f3, alt, rd, rs1, rs2);
		return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_REG};
	endfunction

	function automatic wordT immOp(input int f3, rd, rs1, imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_IMM};
	endfunction

	function automatic wordT lwOp(input int rd, rs1, imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
	endfunction

	function automatic wordT swOp(input int rs2, rs1, imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic wordT branchOp(input int f3, rs1, rs2, off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			OPC_BRANCH};
	endfunction

	function automatic wordT jalOp(input int rd, off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
	endfunction

	function automatic wordT jalrOp(input int rd, rs1, imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_JALR};
	endfunction

	task automatic emit(input wordT word);
		models.loadInstr(progLen, word);
		progLen++;
	endtask

	// Two instructions that must vanish after a redirect
	task automatic emitShadows();
		emit(immOp(0, 31, 31, 1));
		emit(swOp(31, 26, 12));
	endtask

	task automatic buildProgram();
		int kinds [6] = '{0, 1, 4, 5, 6, 7};
		int takenA [6] = '{5, 5, 5, 6, 6, 5};    // x5 = -5, x6 = 7
		int takenB [6] = '{5, 6, 6, 5, 5, 6};
		int notA [6] = '{5, 5, 6, 5, 5, 6};
		int notB [6] = '{6, 5, 5, 6, 6, 5};
		progLen = 0;
		models.resetMemories();
		emit(immOp(0, 1, 0, randomImm()));
		emit(immOp(0, 2, 0, randomImm()));
		emit(immOp(1, 3, 1, 20));
		emit(regOp(6, 0, 3, 3, 2));
		emit(regOp(0, 0, 4, 1, 2));
		emit(regOp(0, 1, 5, 1, 2));    // sub
		emit(regOp(1, 0, 6, 3, 2));
		emit(regOp(2, 0, 7, 1, 2));
		emit(regOp(3, 0, 8, 1, 2));
		emit(regOp(4, 0, 9, 3, 1));
		emit(regOp(5, 0, 10, 3, 2));
		emit(regOp(5, 1, 11, 3, 2));   // sra
		emit(regOp(6, 0, 12, 1, 2));
		emit(regOp(7, 0, 13, 3, 1));
		emit(immOp(5, 14, 3, 'h007));
		emit(immOp(5, 15, 3, 'h407));  // srai
		emit(immOp(4, 16, 3, randomImm()));
		emit(immOp(7, 17, 3, randomImm()));
		emit(immOp(2, 18, 1, randomImm()));
		emit(immOp(3, 19, 1, randomImm()));
		emit(immOp(6, 20, 1, randomImm()));
		// Consumers one, two and three behind x21
		emit(immOp(0, 21, 3, 5));
		emit(regOp(0, 0, 22, 21, 21));
		emit(regOp(4, 0, 23, 21, 4));
		emit(regOp(0, 1, 24, 21, 2));
		emit(immOp(0, 0, 0, 77));
		emit(regOp(0, 0, 25, 0, 1));
		emit(immOp(0, 26, 0, 'h40));
		emit(swOp(3, 26, 0));
		emit(swOp(5, 26, 4));
		emit(lwOp(27, 26, 0));
		emit(regOp(0, 0, 28, 27, 1));
		emit(lwOp(29, 26, 4));
		emit(swOp(29, 26, 8));
		emit(lwOp(30, 26, 8));
		emit(immOp(0, 30, 30, 1));
		emit(immOp(0, 31, 0, 0));
		emit(immOp(0, 5, 0, -5));
		emit(immOp(0, 6, 0, 7));
		for (int k = 0; k < 6; k++)
		begin
			emit(branchOp(kinds[k], takenA[k], takenB[k], 12));
			emitShadows();
			emit(branchOp(kinds[k], notA[k], notB[k], 12));
			emitShadows();
		end
		emit(jalOp(1, 12));
		emitShadows();
		emit(immOp(0, 7, 0, (progLen + 4) * 4));    // JALR target, bit 0 set below
		emit(jalrOp(8, 7, 1));
		emitShadows();
		emit(32'hdead_beff);
		emit(regOp(0, 0, 9, 1, 8));
		emit(branchOp(0, 0, 0, 0));    // Self-loop
	endtask

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (checking && cycle > cycleLimit)
			failRun($sformatf("Timeout at cycle %0d with work still pending", cycle));
	end

	always @(negedge clk)
	begin
		logic [4:0] expRd;
		wordT expData;
		wordT expAddr;
		if (checking)
		begin
			if (cycle == fetchCycle)
			begin
				assert (imemAddr === `PIPE_RESET_PC)
					else reportMismatch("imemAddr", `PIPE_RESET_PC, imemAddr);
				assert (retire.strobe === 1'b0 && dmemReq.write === 1'b0 && dmemReq.read === 1'b0)
					else failRun("A strobe is not low directly after reset");
			end
			if (retire.strobe === 1'b1)
			begin
				if (models.retiresLeft() == 0)
					failRun("Retire pulse with no instruction left to retire");
				models.popRetire(expRd, expData);
				if (!firstRetireSeen)
				begin
					assert (cycle == fetchCycle + 4)
						else failRun("First retire is not four cycles after the first fetch");
					firstRetireSeen = 1'b1;
				end
				assert (retire.rd === expRd)
					else reportMismatch("retire.rd", 32'(expRd), 32'(retire.rd));
				assert (retire.data === expData)
					else reportMismatch("retire.data", expData, retire.data);
			end
			if (dmemReq.write === 1'b1)
			begin
				if (models.storesLeft() == 0)
					failRun("Store issued with no store left in the program");
				models.popStore(expAddr, expData);
				assert (dmemReq.addr === expAddr)
					else reportMismatch("dmemReq.addr", expAddr, dmemReq.addr);
				assert (dmemReq.wdata === expData)
					else reportMismatch("dmemReq.wdata", expData, dmemReq.wdata);
				assert (dmemReq.be === 4'hf)
					else reportMismatch("dmemReq.be", 32'hf, 32'(dmemReq.be));
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		checking = 1'b0;
		firstRetireSeen = 1'b0;
		fetchCycle = 0;
		rng = 32'hc5d2_5eae;
		buildProgram();
		models.runModel();
		cycleLimit = progLen * 6 + 16 + 40;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		fetchCycle = cycle;
		checking = 1'b1;
		while (models.retiresLeft() != 0 || models.storesLeft() != 0)
			@(posedge clk);
		repeat (12) @(posedge clk);    // Self-loop must stay quiet
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: pipeCtrl.sv
`timescale 1ns/100ps

module pipeCtrl
	import pipePkg::*;
(
	input logic [31:0] instr,
	output ctrlT ctrl
);

	logic [2:0] funct3;
	logic bit30;

	assign funct3 = instr[14:12];
	assign bit30 = instr[30];

	always_comb
	begin
		ctrl = '0;    // Unknown opcodes fall through as a bubble
		case (instr[6:0])
			OPC_JAL:
			begin
				ctrl.aluOp = ALU_ADD;
				ctrl.aluSrcA = 1'b0;
				ctrl.aluSrcB = 1'b1;
				ctrl.isJump = 1'b1;
				ctrl.pcSrc = PC_TARGET;
				ctrl.wbSrc = WB_PC4;
				ctrl.regWrite = 1'b1;
				ctrl.valid = 1'b1;
			end
			OPC_JALR:
			begin
				ctrl.aluOp = ALU_ADD;
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 1'b1;
				ctrl.isJump = 1'b1;
				ctrl.pcSrc = PC_TARGET;
				ctrl.wbSrc = WB_PC4;
				ctrl.regWrite = 1'b1;
				ctrl.valid = 1'b1;
			end
			OPC_BRANCH:
			begin
				// Compare rs1 against rs2, target added in execute
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 1'b0;
				ctrl.isBranch = 1'b1;
				ctrl.pcSrc = PC_TARGET;
				ctrl.valid = 1'b1;
				case (funct3)
					3'b000: ctrl.aluOp = ALU_BEQ;
					3'b001: ctrl.aluOp = ALU_BNE;
					3'b100: ctrl.aluOp = ALU_BLT;
					3'b101: ctrl.aluOp = ALU_BGE;
					3'b110: ctrl.aluOp = ALU_BLTU;
					3'b111: ctrl.aluOp = ALU_BGEU;
					default: ctrl = '0;
				endcase
			end
			OPC_LOAD:
			begin
				ctrl.aluOp = ALU_ADD;
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 1'b1;
				ctrl.isLoad = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.wbSrc = WB_MEM;
				ctrl.regWrite = 1'b1;
				ctrl.valid = 1'b1;
			end
			OPC_STORE:
			begin
				ctrl.aluOp = ALU_ADD;
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.valid = 1'b1;
			end
			OPC_IMM:
			begin
				// Bit 30 only matters for shift right
				ctrl.aluOp = aluOpE'({funct3 == 3'b101 && bit30, funct3});
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 1'b1;
				ctrl.wbSrc = WB_ALU;
				ctrl.regWrite = 1'b1;
				ctrl.valid = 1'b1;
			end
			OPC_REG:
			begin
				ctrl.aluOp = aluOpE'({bit30 && (funct3 == 3'b000 || funct3 == 3'b101), funct3});
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 1'b0;
				ctrl.wbSrc = WB_ALU;
				ctrl.regWrite = 1'b1;
				ctrl.valid = 1'b1;
			end
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: pipePkg.sv
`include "pipe_params.svh"

package pipePkg;

	typedef logic [`PIPE_XLEN-1:0] wordT;
	typedef logic [$clog2(`PIPE_NREGS)-1:0] regIdxT;

	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_IMM    = 7'b0010011,
		OPC_STORE  = 7'b0100011,
		OPC_REG    = 7'b0110011,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111
	} opcodeE;

	// Low three bits follow funct3 for the ALU group
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_BEQ  = 4'b1001,
		ALU_BNE  = 4'b1010,
		ALU_BLT  = 4'b1011,
		ALU_BGE  = 4'b1100,
		ALU_SRA  = 4'b1101,
		ALU_BLTU = 4'b1110,
		ALU_BGEU = 4'b1111
	} aluOpE;

	typedef enum logic {
		PC_SEQ,
		PC_TARGET
	} pcSrcE;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wbSrcE;

	typedef struct packed {
		aluOpE aluOp;
		logic aluSrcA;    // 1 register, 0 PC
		logic aluSrcB;    // 1 immediate, 0 register
		logic isJump;
		logic isBranch;
		logic isLoad;
		logic memWrite;
		logic memRead;
		pcSrcE pcSrc;
		wbSrcE wbSrc;
		logic regWrite;
		logic valid;
	} ctrlT;

	typedef struct packed {
		wordT addr;
		wordT wdata;
		logic [3:0] be;
		logic write;
		logic read;
	} dmemReqT;

	typedef struct packed {
		logic strobe;
		regIdxT rd;
		wordT data;
	} retireT;

	typedef struct packed {
		ctrlT ctrl;
		wordT pc;
		wordT rs1Data;
		wordT rs2Data;
		wordT imm;
		regIdxT rs1;
		regIdxT rs2;
		regIdxT rd;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		wordT result;     // ALU result or link address
		wordT storeData;
		regIdxT rd;
	} exMemT;

	typedef struct packed {
		ctrlT ctrl;
		wordT result;
		wordT memData;
		regIdxT rd;
	} memWbT;

endpackage

// File: pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Data and address width
`define PIPE_XLEN 32

// Architectural register count
`define PIPE_NREGS 32

// First fetch address after reset
`define PIPE_RESET_PC 32'h0000_0000

// Depth of instruction ROM and data RAM in words
`define PIPE_MEM_WORDS 256

`endif

// File: regFile.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module regFile
	import pipePkg::*;
(
	input logic clk,
	input logic reset,
	input regIdxT readAddrA,
	input regIdxT readAddrB,
	output wordT readDataA,
	output wordT readDataB,
	input logic writeEn,
	input regIdxT writeAddr,
	input wordT writeData
);

	wordT regs [`PIPE_NREGS];
	logic writeLive;

	assign writeLive = writeEn && (writeAddr != '0);    // x0 stays zero

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `PIPE_NREGS; i++)
				regs[i] <= '0;
		end
		else if (writeLive)
			regs[writeAddr] <= writeData;
	end

	// Write-through
	assign readDataA = (writeLive && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (writeLive && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// File: tbModels.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module tbModels
	import pipePkg::*;
(
	input logic clk,
	input wordT imemAddr,
	output wordT imemData,
	input dmemReqT dmemReq,
	output wordT dmemRdata
);

	localparam int idxBits = $clog2(`PIPE_MEM_WORDS);

	wordT rom [`PIPE_MEM_WORDS];
	wordT ram [`PIPE_MEM_WORDS];
	wordT refRam [`PIPE_MEM_WORDS];
	wordT refRegs [`PIPE_NREGS];
	logic [36:0] retireQ [$];    // {rd, data}
	logic [63:0] storeQ [$];     // {addr, data}

	assign imemData = rom[imemAddr[idxBits+1:2]];
	assign dmemRdata = dmemReq.read ? ram[dmemReq.addr[idxBits+1:2]] : 'x;    // Only on a read

	always @(posedge clk)
	begin
		if (dmemReq.write)
			ram[dmemReq.addr[idxBits+1:2]] <= dmemReq.wdata;
	end

	function automatic wordT fillWord(input int i);
		return 32'h5a3c_0000 ^ (wordT'(i) * 32'h0001_0003);
	endfunction

	task automatic resetMemories();
		for (int i = 0; i < `PIPE_MEM_WORDS; i++)
		begin
			rom[i] = {i[24:0], 7'b1111111};    // Unused words decode as bubbles
			ram[i] = fillWord(i);
		end
	endtask

	task automatic loadInstr(input int idx, input wordT word);
		rom[idx] = word;
	endtask

	function automatic wordT refAlu(input logic [2:0] f3, input logic alt, input wordT a,
		input wordT b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return wordT'($signed(a) < $signed(b));
			3'd3: return wordT'(a < b);
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchTrue(input logic [2:0] f3, input wordT a, input wordT b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic writeBack(input logic [4:0] rd, input wordT value);
		if (rd != 5'd0)
			refRegs[rd] = value;
		retireQ.push_back({rd, (rd == 5'd0) ? 32'h0 : value});    // x0 reports zero
	endtask

	// Runs the ROM program one instruction at a time until it reaches a self-loop
	task automatic runModel();
		wordT pc, nextPc, instr, a, b, addr, immI, immS, immB, immJ;
		logic [4:0] rd;
		int steps;
		for (int i = 0; i < `PIPE_NREGS; i++)
			refRegs[i] = '0;
		for (int i = 0; i < `PIPE_MEM_WORDS; i++)
			refRam[i] = fillWord(i);
		pc = `PIPE_RESET_PC;
		steps = 0;
		forever
		begin
			instr = rom[pc[idxBits+1:2]];
			rd = instr[11:7];
			a = refRegs[instr[19:15]];
			b = refRegs[instr[24:20]];
			immI = {{20{instr[31]}}, instr[31:20]};
			immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			nextPc = pc + 32'd4;
			case (instr[6:0])
				OPC_IMM: writeBack(rd, refAlu(instr[14:12],
					instr[14:12] == 3'd5 && instr[30], a, immI));
				OPC_REG: writeBack(rd, refAlu(instr[14:12], instr[30], a, b));
				OPC_LOAD:
				begin
					addr = a + immI;
					writeBack(rd, refRam[addr[idxBits+1:2]]);
				end
				OPC_STORE:
				begin
					addr = a + immS;
					refRam[addr[idxBits+1:2]] = b;
					storeQ.push_back({addr, b});
				end
				OPC_BRANCH:
				begin
					if (branchTrue(instr[14:12], a, b))
						nextPc = pc + immB;
				end
				OPC_JAL:
				begin
					writeBack(rd, pc + 32'd4);
					nextPc = pc + immJ;
				end
				OPC_JALR:
				begin
					nextPc = (a + immI) & ~32'h1;
					writeBack(rd, pc + 32'd4);
				end
				default: ;    // Illegal opcode does nothing
			endcase
			if (nextPc == pc || steps > 4 * `PIPE_MEM_WORDS)
				break;
			pc = nextPc;
			steps++;
		end
	endtask

	function automatic int retiresLeft();
		return retireQ.size();
	endfunction

	function automatic int storesLeft();
		return storeQ.size();
	endfunction

	task automatic popRetire(output logic [4:0] rd, output wordT data);
		{rd, data} = retireQ.pop_front();
	endtask

	task automatic popStore(output wordT addr, output wordT data);
		{addr, data} = storeQ.pop_front();
	endtask

endmodule
